//--- dv/lookup_vectors.txt
# T name | C last data | L key mask phv | I idle cycle | X action phv
# all fields hex, X lines give the expected result of each lookup in order
T reset_miss
L 000123 000000 0000a5a5c3c30001
X 0000003f 0000a5a5c3c30001
L abcdef ffffff 12f0e1d2c3b4a596
X 0000003f 12f0e1d2c3b4a596
T load_exact
C 0 f1020004
C 0 00111111
C 0 00222222
C 0 00333333
C 0 00123400
C 1 00123456
I
C 0 f1021004
C 0 a0000004
C 0 a0000005
C 0 a0000006
C 0 c0000007
C 1 c0000008
I
L 111111 000000 3c1a00004e2d9f11
X a0000004 3c1a00004e2d9f11
L 222222 000000 70b2c4d600e1f502
X a0000005 70b2c4d600e1f502
L 333333 000000 0f1e2d3c4b5a6978
X a0000006 0f1e2d3c4b5a6978
T masked
L 111100 0000ff 5d3e8a17c2f04b69
X a0000004 5d3e8a17c2f04b69
L 111011 000000 e4a1093b7c6d28f5
X 0000003f e4a1093b7c6d28f5
L 331333 00f000 2b9c7e0f41d6a358
X a0000006 2b9c7e0f41d6a358
T priority
L 123456 0000ff 8f07d2c1e95b3a64
X c0000007 8f07d2c1e95b3a64
L 000000 ffffff 61e4b8a2037fc9d0
X a0000004 61e4b8a2037fc9d0
T foreign
C 0 f1030004
C 1 00999999
C 0 e1021004
C 1 dead0004
I
L 999999 000000 9a2b4c6d8e0f1a3b
X 0000003f 9a2b4c6d8e0f1a3b
L 111111 000000 47c5e3a1f9d7b5c2
X a0000004 47c5e3a1f9d7b5c2
C 0 f1021005
C 1 55555555
I
L 222222 000000 d06e3f9b12a8c754
X 55555555 d06e3f9b12a8c754
T back_to_back
L 111111 000000 1b3d5f7092a4c6e8
X a0000004 1b3d5f7092a4c6e8
L 777777 000000 f2e4d6c8b0a29486
X 0000003f f2e4d6c8b0a29486
L 123456 000000 3a7c1e5f92d4b608
X c0000008 3a7c1e5f92d4b608
L 222222 000000 c8a6e4029f7d5b31
X 55555555 c8a6e4029f7d5b31
L 000001 000000 05f1e9d3a7c2b84e
X 0000003f 05f1e9d3a7c2b84e

//--- verilog.f
+incdir+logic
logic/lookup_pkg.sv
logic/tbl_wr_if.sv
logic/match_if.sv
logic/table_loader.sv
logic/tcam_match.sv
logic/action_fetch.sv
logic/lookup_engine.sv
dv/lookup_checker.sv
dv/tb_lookup.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lookup
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } /^TEST PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)

//--- dv/tb_lookup.sv
// ##############################
// tb_lookup
// testbench top for the lookup stage,
// replays the vector file into the DUT
// ##############################

module tb_lookup;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYC = 200;

    logic                   clk;
    logic                   rst_n;
    logic                   key_valid;
    lookup_pkg::key_t       key;
    lookup_pkg::key_t       key_mask;
    lookup_pkg::phv_t       phv_in;
    logic                   ctrl_valid;
    logic                   ctrl_last;
    lookup_pkg::ctrl_word_t ctrl_data;
    logic                   action_valid;
    lookup_pkg::action_t    action;
    lookup_pkg::phv_t       phv_out;

    logic                   chk_done;
    int                     err_count;
    int                     tests_ok;
    int                     tests_bad;
    int                     wait_cyc;
    logic                   stim_ok;

    lookup_engine u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .key          (key),
        .key_mask     (key_mask),
        .phv_in       (phv_in),
        .ctrl_valid   (ctrl_valid),
        .ctrl_last    (ctrl_last),
        .ctrl_data    (ctrl_data),
        .action_valid (action_valid),
        .action       (action),
        .phv_out      (phv_out)
    );

    lookup_checker u_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .action_valid (action_valid),
        .action       (action),
        .phv_out      (phv_out),
        .done         (chk_done),
        .err_count    (err_count),
        .tests_ok     (tests_ok),
        .tests_bad    (tests_bad)
    );

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic drive_idle();
        key_valid  = 1'b0;
        ctrl_valid = 1'b0;
        ctrl_last  = 1'b0;
    endtask

    // one cycle per C, L or I line, driven on the falling edge
    task automatic replay_vectors(output logic ok);
        int          fd;
        int          n;
        string       line;
        string       rest;
        byte         kind;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        fd = $fopen("dv/lookup_vectors.txt", "r");
        ok = (fd != 0);
        if (fd == 0) begin
            $display("stimulus could not open dv/lookup_vectors.txt");
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0) begin
                kind = line.getc(0);
                rest = line.substr(1, line.len() - 1);
                if (kind == "C") begin
                    n = $sscanf(rest, "%h %h", a, b);
                    @(negedge clk);
                    drive_idle();
                    ctrl_valid = 1'b1;
                    ctrl_last  = a[0];
                    ctrl_data  = b[31:0];
                end else if (kind == "L") begin
                    n = $sscanf(rest, "%h %h %h", a, b, c);
                    @(negedge clk);
                    drive_idle();
                    key_valid = 1'b1;
                    key       = a[23:0];
                    key_mask  = b[23:0];
                    phv_in    = c;
                end else if (kind == "I") begin
                    @(negedge clk);
                    drive_idle();
                end
            end
        end
        $fclose(fd);
        @(negedge clk);
        drive_idle();
    endtask

    initial begin
        rst_n     = 1'b0;
        key       = '0;
        key_mask  = '0;
        phv_in    = '0;
        ctrl_data = '0;
        drive_idle();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        replay_vectors(stim_ok);

        // drain the pipeline
        wait_cyc = 0;
        while (!chk_done && wait_cyc < TIMEOUT_CYC) begin
            @(posedge clk);
            wait_cyc++;
        end
        if (!chk_done) begin
            $display("timeout: expected results still missing after %0d cycles", TIMEOUT_CYC);
        end

        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_ok, tests_bad, err_count);
        if (stim_ok && chk_done && err_count == 0 && tests_bad == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- dv/lookup_checker.sv
// ##############################
// lookup_checker
// compares DUT results with the
// X lines of the vector file
// ##############################

module lookup_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                action_valid,
    input  lookup_pkg::action_t action,
    input  lookup_pkg::phv_t    phv_out,
    output logic                done,
    output int                  err_count,
    output int                  tests_ok,
    output int                  tests_bad
);

    timeunit 1ns;
    timeprecision 1ps;

    string               test_name [$];
    int                  test_left [$];
    int                  test_err  [$];
    lookup_pkg::action_t exp_act   [$];
    lookup_pkg::phv_t    exp_phv   [$];
    int                  exp_test  [$];

    // keeps T and X lines only
    task automatic load_expected();
        int          fd;
        int          n;
        string       line;
        string       rest;
        string       name;
        byte         kind;
        logic [63:0] a;
        logic [63:0] b;
        fd = $fopen("dv/lookup_vectors.txt", "r");
        if (fd == 0) begin
            $display("checker could not open dv/lookup_vectors.txt");
            err_count++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0) begin
                kind = line.getc(0);
                rest = line.substr(1, line.len() - 1);
                if (kind == "T") begin
                    n = $sscanf(rest, "%s", name);
                    test_name.push_back(name);
                    test_left.push_back(0);
                    test_err.push_back(0);
                end else if (kind == "X" && test_name.size() > 0) begin
                    n = $sscanf(rest, "%h %h", a, b);
                    exp_act.push_back(a[31:0]);
                    exp_phv.push_back(b);
                    exp_test.push_back(test_name.size() - 1);
                    test_left[test_name.size() - 1] = test_left[test_name.size() - 1] + 1;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_result();
        int                  t;
        lookup_pkg::action_t e_act;
        lookup_pkg::phv_t    e_phv;
        if (exp_act.size() == 0) begin
            $display("unexpected result at %0d ns with no lookup outstanding", $time);
            err_count++;
            return;
        end
        t     = exp_test.pop_front();
        e_act = exp_act.pop_front();
        e_phv = exp_phv.pop_front();
        if (action !== e_act) begin
            $display("ERROR at %0d ns: action expected %h actual %h", $time, e_act, action);
            test_err[t] = test_err[t] + 1;
            err_count++;
        end
        if (phv_out !== e_phv) begin
            $display("ERROR at %0d ns: phv_out expected %h actual %h", $time, e_phv, phv_out);
            test_err[t] = test_err[t] + 1;
            err_count++;
        end
        test_left[t] = test_left[t] - 1;
        // last result of the test closes it
        if (test_left[t] == 0) begin
            if (test_err[t] == 0) begin
                $display("test %s: pass", test_name[t]);
                tests_ok++;
            end else begin
                $display("test %s: fail with %0d errors", test_name[t], test_err[t]);
                tests_bad++;
            end
        end
    endtask

    // sample mid cycle once the outputs have settled
    initial begin
        err_count = 0;
        tests_ok  = 0;
        tests_bad = 0;
        done      = 1'b0;
        load_expected();
        done = (exp_act.size() == 0);
        forever begin
            @(negedge clk);
            if (rst_n && action_valid) begin
                check_result();
            end
            done = (exp_act.size() == 0);
        end
    end

endmodule

//--- logic/lookup_engine.sv
// ##############################
// lookup_engine
// single match-action lookup stage,
// 3-cycle pipelined lookup with
// tables loaded from a control stream
// ##############################

`include "lookup_defines.svh"

module lookup_engine #(
    parameter int unsigned STAGE_ID  = `LOOKUP_STAGE_ID,
    parameter int unsigned LOOKUP_ID = `LOOKUP_LOOKUP_ID
) (
    input  logic                   clk,
    input  logic                   rst_n,

    // lookup side
    input  logic                   key_valid,
    input  lookup_pkg::key_t       key,
    input  lookup_pkg::key_t       key_mask,
    input  lookup_pkg::phv_t       phv_in,

    // control stream
    input  logic                   ctrl_valid,
    input  logic                   ctrl_last,
    input  lookup_pkg::ctrl_word_t ctrl_data,

    // result, valid for one cycle, no back-pressure
    output logic                   action_valid,
    output lookup_pkg::action_t    action,
    output lookup_pkg::phv_t       phv_out
);

    tbl_wr_if wr_bus ();
    match_if  res_bus ();

    table_loader #(
        .STAGE_ID  (STAGE_ID),
        .LOOKUP_ID (LOOKUP_ID)
    ) u_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl_valid (ctrl_valid),
        .ctrl_last  (ctrl_last),
        .ctrl_data  (ctrl_data),
        .wr         (wr_bus.loader)
    );

    // first pipeline stage
    tcam_match u_match (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_valid (key_valid),
        .key       (key),
        .key_mask  (key_mask),
        .phv_in    (phv_in),
        .wr        (wr_bus.cam),
        .res       (res_bus.src)
    );

    // read and output stages
    action_fetch u_action (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr           (wr_bus.act),
        .res          (res_bus.dst),
        .action_valid (action_valid),
        .action       (action),
        .phv_out      (phv_out)
    );

endmodule

//--- logic/action_fetch.sv
// ##############################
// action_fetch
// action table, registered read and
// default action on a miss
// ##############################

`include "lookup_defines.svh"

module action_fetch (
    input  logic                clk,
    input  logic                rst_n,
    tbl_wr_if.act               wr,
    match_if.dst                res,
    output logic                action_valid,
    output lookup_pkg::action_t action,
    output lookup_pkg::phv_t    phv_out
);

    lookup_pkg::action_t act_mem [`LOOKUP_DEPTH];
    lookup_pkg::action_t rd_act;
    logic                s1_valid;
    logic                s1_hit;
    lookup_pkg::phv_t    s1_phv;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `LOOKUP_DEPTH; i++) begin
                act_mem[i] <= '0;
            end
        end else if (wr.act_we) begin
            act_mem[wr.idx] <= wr.data;
        end
    end

    // stage 1 reads the table
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= res.valid;
        end
    end

    always_ff @(posedge clk) begin
        rd_act <= act_mem[res.idx];
        s1_hit <= res.hit;
        s1_phv <= res.phv;
    end

    // stage 2 picks the table action or the default
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            action_valid <= 1'b0;
        end else begin
            action_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        action  <= s1_hit ? rd_act : `LOOKUP_DEFAULT_ACT;
        phv_out <= s1_phv;
    end

    // output lags the match result by two cycles
    a_out_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        action_valid |-> $past(s1_valid) && $past(res.valid, 2)
    );

endmodule

//--- logic/tcam_match.sv
// ##############################
// tcam_match
// match table, masked compare and
// lowest-index priority encode
// ##############################

`include "lookup_defines.svh"

module tcam_match (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             key_valid,
    input  lookup_pkg::key_t key,
    input  lookup_pkg::key_t key_mask,
    input  lookup_pkg::phv_t phv_in,
    tbl_wr_if.cam            wr,
    match_if.src             res
);

    lookup_pkg::key_t           entry_key [`LOOKUP_DEPTH];
    logic [`LOOKUP_DEPTH-1:0]   entry_vld;
    logic [`LOOKUP_DEPTH-1:0]   match_vec;
    lookup_pkg::index_t         hit_idx;
    logic                       any_hit;

    // entry store, a write also marks the entry valid
    always_ff @(posedge clk) begin
        if (wr.cam_we) begin
            entry_key[wr.idx] <= wr.data[`LOOKUP_KEY_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_vld <= '0;
        end else if (wr.cam_we) begin
            entry_vld[wr.idx] <= 1'b1;
        end
    end

    // mask bit set means don't care
    always_comb begin
        for (int i = 0; i < `LOOKUP_DEPTH; i++) begin
            match_vec[i] = entry_vld[i] &&
                           (((entry_key[i] ^ key) & ~key_mask) == '0);
        end
    end

    // scan from the top so the lowest index is kept
    always_comb begin
        hit_idx = '0;
        any_hit = 1'b0;
        for (int i = `LOOKUP_DEPTH - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                hit_idx = lookup_pkg::index_t'(i);
                any_hit = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res.valid <= 1'b0;
            res.hit   <= 1'b0;
        end else begin
            res.valid <= key_valid;
            res.hit   <= key_valid && any_hit;
        end
    end

    always_ff @(posedge clk) begin
        res.idx <= hit_idx;
        res.phv <= phv_in;
    end

    a_hit_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        res.hit |-> res.valid
    );

endmodule

//--- logic/table_loader.sv
// ##############################
// table_loader
// parses the control stream into
// match and action table writes
// ##############################

`include "lookup_defines.svh"

module table_loader #(
    parameter int unsigned STAGE_ID  = `LOOKUP_STAGE_ID,
    parameter int unsigned LOOKUP_ID = `LOOKUP_LOOKUP_ID
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ctrl_valid,
    input  logic                   ctrl_last,
    input  lookup_pkg::ctrl_word_t ctrl_data,
    tbl_wr_if.loader               wr
);

    lookup_pkg::loader_state_t state;
    lookup_pkg::index_t        next_idx;

    logic [7:0]                tag;
    logic [7:0]                mod_id;
    logic [3:0]                sel;
    lookup_pkg::index_t        start_idx;
    logic                      hdr_ok;

    // header fields, only meaningful in LD_IDLE
    assign tag       = ctrl_data[`LOOKUP_CTRL_W-1 -: 8];
    assign mod_id    = ctrl_data[`LOOKUP_MODID_POS +: 8];
    assign sel       = ctrl_data[`LOOKUP_SEL_POS +: 4];
    assign start_idx = ctrl_data[`LOOKUP_IDX_POS +: `LOOKUP_IDX_W];

    // upper 5 bits stage id, lower 3 bits lookup id
    assign hdr_ok = (tag == `LOOKUP_CTRL_MAGIC) &&
                    (mod_id[7:3] == 5'(STAGE_ID)) &&
                    (mod_id[2:0] == 3'(LOOKUP_ID));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= lookup_pkg::LD_IDLE;
            next_idx <= '0;
        end else if (ctrl_valid) begin
            case (state)
                lookup_pkg::LD_IDLE: begin
                    next_idx <= start_idx;
                    // a header that is also last has no entries
                    if (ctrl_last) begin
                        state <= lookup_pkg::LD_IDLE;
                    end else if (!hdr_ok) begin
                        state <= lookup_pkg::LD_SKIP;
                    end else if (sel == 4'd0) begin
                        state <= lookup_pkg::LD_CAM;
                    end else begin
                        state <= lookup_pkg::LD_ACT;
                    end
                end
                lookup_pkg::LD_CAM,
                lookup_pkg::LD_ACT: begin
                    // one entry per beat, index walks up
                    next_idx <= lookup_pkg::index_t'(next_idx + 1'b1);
                    if (ctrl_last) begin
                        state <= lookup_pkg::LD_IDLE;
                    end
                end
                default: begin
                    // foreign packet, drop beats until its last
                    if (ctrl_last) begin
                        state <= lookup_pkg::LD_IDLE;
                    end
                end
            endcase
        end
    end

    // write strobes, one cycle after the entry beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr.cam_we <= 1'b0;
            wr.act_we <= 1'b0;
        end else begin
            wr.cam_we <= ctrl_valid && (state == lookup_pkg::LD_CAM);
            wr.act_we <= ctrl_valid && (state == lookup_pkg::LD_ACT);
        end
    end

    // entry payload and its address
    always_ff @(posedge clk) begin
        if (ctrl_valid) begin
            wr.idx  <= next_idx;
            wr.data <= ctrl_data;
        end
    end

    // only one table is written per beat
    a_one_table: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wr.cam_we && wr.act_we)
    );

endmodule

//--- logic/match_if.sv
// ##############################
// match_if
// registered match result, match
// stage to action stage
// ##############################

interface match_if;

    // one strobe per lookup
    logic               valid;
    logic               hit;
    lookup_pkg::index_t idx;
    lookup_pkg::phv_t   phv;

    modport src (output valid, output hit, output idx, output phv);

    modport dst (input valid, input hit, input idx, input phv);

endinterface

//--- logic/tbl_wr_if.sv
// ##############################
// tbl_wr_if
// table write port, loader to the
// match and action tables
// ##############################

interface tbl_wr_if;

    logic                  cam_we;
    logic                  act_we;
    lookup_pkg::index_t    idx;
    lookup_pkg::ctrl_word_t data;

    modport loader (output cam_we, output act_we, output idx, output data);

    modport cam (input cam_we, input idx, input data);

    modport act (input act_we, input idx, input data);

endinterface

//--- logic/lookup_pkg.sv
// ##############################
// lookup_pkg
// shared types of the lookup stage
// ##############################

`include "lookup_defines.svh"

package lookup_pkg;

    // key and its don't-care mask
    typedef logic [`LOOKUP_KEY_W-1:0]  key_t;

    typedef logic [`LOOKUP_ACT_W-1:0]  action_t;

    // packet header vector, carried alongside the lookup
    typedef logic [`LOOKUP_PHV_W-1:0]  phv_t;

    typedef logic [`LOOKUP_IDX_W-1:0]  index_t;

    // one beat of the control stream
    typedef logic [`LOOKUP_CTRL_W-1:0] ctrl_word_t;

    // table loader states
    typedef enum logic [1:0] {
        LD_IDLE = 2'd0,
        LD_CAM  = 2'd1,
        LD_ACT  = 2'd2,
        LD_SKIP = 2'd3
    } loader_state_t;

endpackage

//--- logic/lookup_defines.svh
// ##############################
// lookup stage defines
// widths, table depth, control header
// layout and the miss action
// ##############################

`ifndef LOOKUP_DEFINES_SVH
`define LOOKUP_DEFINES_SVH

// datapath widths
`define LOOKUP_KEY_W        24
`define LOOKUP_ACT_W        32
`define LOOKUP_PHV_W        64

// both tables share depth and index
`define LOOKUP_DEPTH        16
`define LOOKUP_IDX_W        4

// control header beat, tag sits in the top byte
`define LOOKUP_CTRL_W       32
`define LOOKUP_CTRL_MAGIC   8'hf1
`define LOOKUP_MODID_POS    16
`define LOOKUP_SEL_POS      12
`define LOOKUP_IDX_POS      0

`define LOOKUP_DEFAULT_ACT  32'h3f
`define LOOKUP_STAGE_ID     0
`define LOOKUP_LOOKUP_ID    2

`endif
